//--- Bender.yml
package:
  name: wbb

sources:
  - common/wbb_pkg.sv
  - wb_bridge/wb_bridge_master.sv
  - rtl/wb_addr_decode.sv
  - wb_ram/wb_ram.sv
  - rtl/wb_status_regs.sv
  - rtl/wbb_top.sv
  - target: test
    files:
      - dv/wbb_tb.sv

//--- common/wbb_pkg.sv
// ****************************************
// Address map and word types for a 16-bit Wishbone system
// Byte addresses, with bit 0 always clear on the bus
// ****************************************

package wbb_pkg;

  // Full Wishbone byte address
  typedef logic [31:0] addr_t;

  // Word address as the core drives it, bit 0 implied zero
  typedef logic [31:1] word_addr_t;

  // One bus data word
  typedef logic [15:0] data_t;

  // Byte-lane select, bit 1 is the high byte
  typedef logic [1:0] sel_t;

  // RAM geometry
  localparam int unsigned RAM_WORDS = 512;
  localparam int unsigned RAM_AW = 9;

  // Region boundaries
  // Bit 31 alone selects the status block
  localparam addr_t REGS_BASE = 32'h8000_0000;
  // First byte address past the end of the RAM
  localparam addr_t RAM_LIMIT = 32'h0000_0400;

  // Status block byte offsets from REGS_BASE
  localparam addr_t REG_SCRATCH = 32'd0;
  localparam addr_t REG_CTRL = 32'd2;
  localparam addr_t REG_ID = 32'd4;

  // Fixed identity word, read-only
  localparam data_t ID_VALUE = 16'h4d4c;

  // Read data for addresses outside every region
  localparam data_t UNMAPPED_DATA = 16'hffff;

endpackage

//--- dv/wbb_tb.sv
// ****************************************
// Plays the core at the top-level ports and stops at the first error
// RAM words are only read back after a full-word write
// ****************************************
`timescale 1ns/1ps

module wbb_tb;

  import wbb_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int HALF_PERIOD = CLK_PERIOD / 2;
  localparam int RST_CYCLES = 10;
  localparam int N_RAND = 16;
  // Status 10, round trip 2 per word, lanes 6, unmapped 6, final sweep 1 per word
  localparam int N_ACCESSES = 10 + 3 * N_RAND + 6 + 6;
  // At most 4 cycles per access, plus reset and a small margin
  localparam int WATCHDOG_NS = (N_ACCESSES * 4 + RST_CYCLES + 4) * CLK_PERIOD;

  logic       clk_i;
  logic       rst_i;
  word_addr_t cpu_addr;
  data_t      cpu_dat_w;
  logic       cpu_rd_n;
  logic       cpu_wr_n;
  logic       cpu_wr_h_n;
  logic       cpu_wr_l_n;
  data_t      cpu_dat_r;
  logic       cpu_wait;
  logic       irq;

  // Shadow of the RAM contents
  data_t             shadow [RAM_WORDS];
  logic [RAM_AW-1:0] idx_list [N_RAND];
  data_t             scratch_exp;
  int                seed;

  wbb_top u_dut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cpu_addr_i   (cpu_addr),
    .cpu_dat_i    (cpu_dat_w),
    .cpu_rd_n_i   (cpu_rd_n),
    .cpu_wr_n_i   (cpu_wr_n),
    .cpu_wr_h_n_i (cpu_wr_h_n),
    .cpu_wr_l_n_i (cpu_wr_l_n),
    .cpu_dat_o    (cpu_dat_r),
    .cpu_wait_o   (cpu_wait),
    .irq_o        (irq)
  );

  always #(HALF_PERIOD) clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [15:0] exp_val,
                             input logic [15:0] act_val);
    string line;
    assert (act_val === exp_val) else begin
      line = $sformatf("FAILED t=%0t %s expected %h actual %h",
                       $time, name, exp_val, act_val);
      abort_run(line);
    end
  endtask

  // Byte address of a RAM word
  function automatic addr_t ram_addr(input logic [RAM_AW-1:0] idx);
    return {22'd0, idx, 1'b0};
  endfunction

  // One core access, held until wait is low, then one extra strobe cycle
  task automatic cpu_access(input bit is_wr, input addr_t byte_addr, input data_t wdata,
                            input bit hi_n, input bit lo_n, input int exp_waits,
                            output data_t rdata);
    int waits;
    bit done;
    waits = 0;
    done = 1'b0;
    rdata = '0;
    @(negedge clk_i);
    cpu_addr = byte_addr[31:1];
    cpu_dat_w = wdata;
    cpu_rd_n = is_wr;
    cpu_wr_n = ~is_wr;
    cpu_wr_h_n = is_wr ? hi_n : 1'b1;
    cpu_wr_l_n = is_wr ? lo_n : 1'b1;
    while (!done) begin
      // Sample 1 ns ahead of the rising edge
      #(HALF_PERIOD - 1);
      if (!cpu_wait) begin
        done = 1'b1;
        rdata = cpu_dat_r;
      end else begin
        waits++;
      end
      @(posedge clk_i);
      if (!done) begin
        @(negedge clk_i);
      end
    end
    check_value("cpu_wait_o cycles", exp_waits[15:0], waits[15:0]);
    // Strobe still held, no new bus cycle may open
    @(negedge clk_i);
    check_value("cpu_wait_o", 16'd0, {15'd0, cpu_wait});
    check_value("wb_cyc", 16'd0, {15'd0, u_dut.wb_cyc});
    cpu_rd_n = 1'b1;
    cpu_wr_n = 1'b1;
    cpu_wr_h_n = 1'b1;
    cpu_wr_l_n = 1'b1;
  endtask

  task automatic bus_write(input addr_t byte_addr, input data_t wdata, input bit hi_n,
                           input bit lo_n, input int exp_waits);
    data_t unused;
    cpu_access(1'b1, byte_addr, wdata, hi_n, lo_n, exp_waits, unused);
  endtask

  task automatic bus_read(input string name, input addr_t byte_addr, input data_t exp_data,
                          input int exp_waits);
    data_t rdata;
    cpu_access(1'b0, byte_addr, '0, 1'b1, 1'b1, exp_waits, rdata);
    check_value(name, exp_data, rdata);
  endtask

  // RAM write, shadow follows the active lanes
  task automatic ram_write(input logic [RAM_AW-1:0] idx, input data_t wdata,
                           input bit hi_n, input bit lo_n);
    bus_write(ram_addr(idx), wdata, hi_n, lo_n, 1);
    if (!hi_n) begin
      shadow[idx][15:8] = wdata[15:8];
    end
    if (!lo_n) begin
      shadow[idx][7:0] = wdata[7:0];
    end
  endtask

  task automatic ram_check(input logic [RAM_AW-1:0] idx);
    string name;
    name = $sformatf("cpu_dat_o ram[%0d]", idx);
    bus_read(name, ram_addr(idx), shadow[idx], 1);
  endtask

  initial begin : main
    int    r;
    data_t wdata;
    seed = 32'h5a2c_7b87;
    clk_i = 1'b0;
    rst_i = 1'b1;
    cpu_addr = '0;
    cpu_dat_w = '0;
    cpu_rd_n = 1'b1;
    cpu_wr_n = 1'b1;
    cpu_wr_h_n = 1'b1;
    cpu_wr_l_n = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    // Status block reset values
    check_value("irq_o", 16'd0, {15'd0, irq});
    bus_read("cpu_dat_o scratch", REGS_BASE + REG_SCRATCH, 16'h0000, 0);
    bus_read("cpu_dat_o ctrl", REGS_BASE + REG_CTRL, 16'h0000, 0);
    // Scratch full word, then high lane only
    scratch_exp = 16'h1234;
    bus_write(REGS_BASE + REG_SCRATCH, 16'h1234, 1'b0, 1'b0, 0);
    bus_read("cpu_dat_o scratch", REGS_BASE + REG_SCRATCH, scratch_exp, 0);
    bus_write(REGS_BASE + REG_SCRATCH, 16'hab00, 1'b0, 1'b1, 0);
    scratch_exp[15:8] = 8'hab;
    bus_read("cpu_dat_o scratch", REGS_BASE + REG_SCRATCH, scratch_exp, 0);
    // Control bit 0 raises the interrupt
    bus_write(REGS_BASE + REG_CTRL, 16'h0001, 1'b0, 1'b0, 0);
    check_value("irq_o", 16'd1, {15'd0, irq});
    bus_read("cpu_dat_o ctrl", REGS_BASE + REG_CTRL, 16'h0001, 0);
    // Identity word ignores the write
    bus_write(REGS_BASE + REG_ID, 16'h0000, 1'b0, 1'b0, 0);
    bus_read("cpu_dat_o id", REGS_BASE + REG_ID, 16'h4d4c, 0);

    // RAM round trip at random words
    for (int i = 0; i < N_RAND; i++) begin
      r = $random(seed);
      idx_list[i] = r[RAM_AW-1:0];
      r = $random(seed);
      ram_write(idx_list[i], r[15:0], 1'b0, 1'b0);
    end
    for (int i = 0; i < N_RAND; i++) begin
      ram_check(idx_list[i]);
    end

    // Single lanes, then no lane; inverted data makes every change visible
    wdata = ~shadow[idx_list[0]];
    ram_write(idx_list[0], wdata, 1'b0, 1'b1);
    ram_check(idx_list[0]);
    wdata = ~shadow[idx_list[1]];
    ram_write(idx_list[1], wdata, 1'b1, 1'b0);
    ram_check(idx_list[1]);
    wdata = ~shadow[idx_list[2]];
    ram_write(idx_list[2], wdata, 1'b1, 1'b1);
    ram_check(idx_list[2]);

    // Unmapped reads answer at once with all ones
    bus_read("cpu_dat_o unmapped", RAM_LIMIT, 16'hffff, 0);
    bus_read("cpu_dat_o unmapped", 32'h4000_0000, 16'hffff, 0);
    // Same bits 9..1 as a RAM word, but bit 10 set
    wdata = ~shadow[idx_list[3]];
    bus_write(RAM_LIMIT + ram_addr(idx_list[3]), wdata, 1'b0, 1'b0, 0);
    // Just past the identity word
    bus_write(REGS_BASE + 32'd8, 16'h0f0f, 1'b0, 1'b0, 0);
    ram_check(idx_list[3]);
    bus_read("cpu_dat_o scratch", REGS_BASE + REG_SCRATCH, scratch_exp, 0);

    // Final back-to-back sweep at the minimum gap
    for (int i = 0; i < N_RAND; i++) begin
      ram_check(idx_list[i]);
    end

    $display("all tests passed");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    abort_run("Timeout: the bus accesses did not finish in the expected time");
  end

endmodule

//--- rtl/wb_addr_decode.sv
// ****************************************
// Combinational only, one slave selected per address
// Unmapped writes are dropped without an error
// ****************************************
`timescale 1ns/1ps

module wb_addr_decode (
  // From the bridge
  input  wbb_pkg::addr_t wb_adr_i,
  input  logic           wb_stb_i,
  output wbb_pkg::data_t wb_dat_o,
  output logic           wb_ack_o,
  // RAM slave
  output logic           ram_stb_o,
  input  wbb_pkg::data_t ram_dat_i,
  input  logic           ram_ack_i,
  // Status register slave
  output logic           regs_stb_o,
  input  wbb_pkg::data_t regs_dat_i,
  input  logic           regs_ack_i
);

  import wbb_pkg::*;

  logic  hit_ram;
  logic  hit_regs;
  addr_t regs_off;

  // Offset inside the status region
  assign regs_off = wb_adr_i - REGS_BASE;

  // RAM sits at the bottom of the map
  assign hit_ram = (wb_adr_i < RAM_LIMIT);

  // Status block is three words from REGS_BASE up
  assign hit_regs = (wb_adr_i >= REGS_BASE) && (regs_off < (REG_ID + 32'd2));

  // Strobe reaches the matching slave only
  assign ram_stb_o = wb_stb_i & hit_ram;
  assign regs_stb_o = wb_stb_i & hit_regs;

  // Return path
  always_comb begin
    if (hit_ram) begin
      wb_dat_o = ram_dat_i;
      wb_ack_o = ram_ack_i;
    end else if (hit_regs) begin
      wb_dat_o = regs_dat_i;
      wb_ack_o = regs_ack_i;
    end else begin
      // Unmapped, answer at once with all ones
      wb_dat_o = UNMAPPED_DATA;
      wb_ack_o = wb_stb_i;
    end
  end

endmodule

//--- rtl/wb_status_regs.sv
// ****************************************
// Zero wait states, ack is stb
// Only control bit 0 is stored, it drives irq_o
// ****************************************
`timescale 1ns/1ps

module wb_status_regs (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           stb_i,
  input  logic           we_i,
  input  wbb_pkg::addr_t adr_i,
  input  wbb_pkg::sel_t  sel_i,
  input  wbb_pkg::data_t dat_i,
  output wbb_pkg::data_t dat_o,
  output logic           ack_o,
  output logic           irq_o
);

  import wbb_pkg::*;

  addr_t reg_off;
  data_t scratch_q;
  logic  ctrl_q;
  logic  wr_en;

  // Offset from the region base
  assign reg_off = adr_i - REGS_BASE;

  assign wr_en = stb_i & we_i;

  // Scratch and control registers
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      scratch_q <= '0;
      ctrl_q <= 1'b0;
    end else if (wr_en) begin
      if (reg_off == REG_SCRATCH) begin
        // Byte lanes apply to scratch
        if (sel_i[0]) begin
          scratch_q[7:0] <= dat_i[7:0];
        end
        if (sel_i[1]) begin
          scratch_q[15:8] <= dat_i[15:8];
        end
      end else if (reg_off == REG_CTRL) begin
        // Bit 0 lives in the low lane
        if (sel_i[0]) begin
          ctrl_q <= dat_i[0];
        end
      end
      // Identity word ignores writes
    end
  end

  // Read mux
  always_comb begin
    if (reg_off == REG_SCRATCH) begin
      dat_o = scratch_q;
    end else if (reg_off == REG_CTRL) begin
      // Upper control bits read as zero
      dat_o = {15'd0, ctrl_q};
    end else if (reg_off == REG_ID) begin
      dat_o = ID_VALUE;
    end else begin
      dat_o = '0;
    end
  end

  // No wait states
  assign ack_o = stb_i;

  assign irq_o = ctrl_q;

endmodule

//--- rtl/wbb_top.sv
// ****************************************
// Single core master, RAM and status slaves
// ****************************************
`timescale 1ns/1ps

module wbb_top (
  input  logic                clk_i,
  input  logic                rst_i,
  // Core side
  input  wbb_pkg::word_addr_t cpu_addr_i,
  input  wbb_pkg::data_t      cpu_dat_i,
  input  logic                cpu_rd_n_i,
  input  logic                cpu_wr_n_i,
  input  logic                cpu_wr_h_n_i,
  input  logic                cpu_wr_l_n_i,
  output wbb_pkg::data_t      cpu_dat_o,
  output logic                cpu_wait_o,
  // Interrupt from the control register
  output logic                irq_o
);

  import wbb_pkg::*;

  // Master bus
  addr_t wb_adr;
  data_t wb_dat_w;
  data_t wb_dat_r;
  sel_t  wb_sel;
  logic  wb_we;
  logic  wb_cyc;
  logic  wb_stb;
  logic  wb_ack;

  // Per-slave returns
  logic  ram_stb;
  logic  ram_ack;
  data_t ram_dat;
  logic  regs_stb;
  logic  regs_ack;
  data_t regs_dat;

  wb_bridge_master u_bridge (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cpu_addr_i   (cpu_addr_i),
    .cpu_dat_i    (cpu_dat_i),
    .cpu_rd_n_i   (cpu_rd_n_i),
    .cpu_wr_n_i   (cpu_wr_n_i),
    .cpu_wr_h_n_i (cpu_wr_h_n_i),
    .cpu_wr_l_n_i (cpu_wr_l_n_i),
    .cpu_dat_o    (cpu_dat_o),
    .cpu_wait_o   (cpu_wait_o),
    .wb_adr_o     (wb_adr),
    .wb_dat_o     (wb_dat_w),
    .wb_sel_o     (wb_sel),
    .wb_we_o      (wb_we),
    .wb_cyc_o     (wb_cyc),
    .wb_stb_o     (wb_stb),
    .wb_dat_i     (wb_dat_r),
    .wb_ack_i     (wb_ack)
  );

  // Slaves are single-master, stb already implies cyc
  wb_addr_decode u_decode (
    .wb_adr_i   (wb_adr),
    .wb_stb_i   (wb_stb & wb_cyc),
    .wb_dat_o   (wb_dat_r),
    .wb_ack_o   (wb_ack),
    .ram_stb_o  (ram_stb),
    .ram_dat_i  (ram_dat),
    .ram_ack_i  (ram_ack),
    .regs_stb_o (regs_stb),
    .regs_dat_i (regs_dat),
    .regs_ack_i (regs_ack)
  );

  wb_ram u_ram (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .stb_i (ram_stb),
    .we_i  (wb_we),
    .adr_i (wb_adr),
    .sel_i (wb_sel),
    .dat_i (wb_dat_w),
    .dat_o (ram_dat),
    .ack_o (ram_ack)
  );

  wb_status_regs u_regs (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .stb_i (regs_stb),
    .we_i  (wb_we),
    .adr_i (wb_adr),
    .sel_i (wb_sel),
    .dat_i (wb_dat_w),
    .dat_o (regs_dat),
    .ack_o (regs_ack),
    .irq_o (irq_o)
  );

endmodule

//--- verilog.f
common/wbb_pkg.sv
wb_bridge/wb_bridge_master.sv
rtl/wb_addr_decode.sv
wb_ram/wb_ram.sv
rtl/wb_status_regs.sv
rtl/wbb_top.sv
dv/wbb_tb.sv

//--- wb_bridge/wb_bridge_master.sv
// ****************************************
// Core must hold strobe, address and data until wait is low
// Strobe released one cycle after completion
// ****************************************
`timescale 1ns/1ps

module wb_bridge_master (
  input  logic                clk_i,
  input  logic                rst_i,
  // Core side
  input  wbb_pkg::word_addr_t cpu_addr_i,
  input  wbb_pkg::data_t      cpu_dat_i,
  input  logic                cpu_rd_n_i,
  input  logic                cpu_wr_n_i,
  input  logic                cpu_wr_h_n_i,
  input  logic                cpu_wr_l_n_i,
  output wbb_pkg::data_t      cpu_dat_o,
  output logic                cpu_wait_o,
  // Wishbone master side
  output wbb_pkg::addr_t      wb_adr_o,
  output wbb_pkg::data_t      wb_dat_o,
  output wbb_pkg::sel_t       wb_sel_o,
  output logic                wb_we_o,
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  input  wbb_pkg::data_t      wb_dat_i,
  input  logic                wb_ack_i
);

  import wbb_pkg::*;

  // IDLE   no cycle open, core strobe passes straight to stb
  // ACCESS cycle open, waiting for the slave ack
  // DONE   one cycle after ack, stb masked
  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    DONE
  } state_e;

  state_e state_q;
  state_e state_d;

  logic cpu_strobe;
  logic stb_mask;

  // Either strobe low means the core wants the bus
  assign cpu_strobe = ~(cpu_rd_n_i & cpu_wr_n_i);

  // Only DONE blocks the strobe
  assign stb_mask = (state_q == DONE);

  // Address and payload go through untouched
  assign wb_adr_o = {cpu_addr_i, 1'b0};
  assign wb_dat_o = cpu_dat_i;
  assign cpu_dat_o = wb_dat_i;

  // Reads take both lanes, writes take the lane strobes inverted
  assign wb_we_o = ~cpu_wr_n_i;
  assign wb_sel_o = cpu_wr_n_i ? sel_t'(2'b11) : {~cpu_wr_h_n_i, ~cpu_wr_l_n_i};

  // Classic single cycles, cyc is a copy of stb
  assign wb_stb_o = cpu_strobe & ~stb_mask;
  assign wb_cyc_o = wb_stb_o;

  // Stall the core until the slave answers
  // Low in DONE so a held strobe never stalls
  assign cpu_wait_o = cpu_strobe & ~wb_ack_i & ~stb_mask;

  // Next-state logic
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // Zero-wait slaves ack in the same cycle as stb
        if (wb_stb_o && wb_ack_i) begin
          state_d = DONE;
        end else if (wb_stb_o) begin
          state_d = ACCESS;
        end
      end
      ACCESS: begin
        if (wb_ack_i) begin
          state_d = DONE;
        end else if (!cpu_strobe) begin
          // Core gave up the access, close the cycle
          state_d = IDLE;
        end
      end
      DONE: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- wb_ram/wb_ram.sv
// ****************************************
// One wait state, contents undefined after reset
// Only address bits 9..1 are decoded
// ****************************************
`timescale 1ns/1ps

module wb_ram (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           stb_i,
  input  logic           we_i,
  input  wbb_pkg::addr_t adr_i,
  input  wbb_pkg::sel_t  sel_i,
  input  wbb_pkg::data_t dat_i,
  output wbb_pkg::data_t dat_o,
  output logic           ack_o
);

  import wbb_pkg::*;

  data_t mem [RAM_WORDS];

  logic [RAM_AW-1:0] word_idx;
  logic              ack_q;
  logic              issue;
  data_t             rd_q;

  // Word index from the byte address
  assign word_idx = adr_i[RAM_AW:1];

  // New access seen, ack goes out on this edge
  // ack_q blocks a second ack while stb is still high
  assign issue = stb_i & ~ack_q;

  // Ack pulse, exactly one cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= issue;
    end
  end

  // Storage and read register
  always_ff @(posedge clk_i) begin
    if (issue) begin
      // Read data lines up with the ack
      rd_q <= mem[word_idx];
      if (we_i) begin
        if (sel_i[0]) begin
          mem[word_idx][7:0] <= dat_i[7:0];
        end
        if (sel_i[1]) begin
          mem[word_idx][15:8] <= dat_i[15:8];
        end
      end
    end
  end

  assign ack_o = ack_q;
  assign dat_o = rd_q;

endmodule
